//--- common/dii_pkg.sv
// debug ring types, size constants and scm register map; imported by every ring module
`default_nettype none

package dii_pkg;
   // ring stops, counting the scm stop
   localparam int NUM_MODULES = 4;
   // longest packet in flits
   localparam int MAX_PKT_LEN = 8;
   localparam int PTR_W = $clog2(MAX_PKT_LEN);
   localparam int LEN_W = $clog2(MAX_PKT_LEN + 1);

   localparam logic [15:0] SYSTEM_VENDOR_ID = 16'h0001;
   localparam logic [15:0] SYSTEM_DEVICE_ID = 16'h0042;

   // outside the router id range, so it circles back to the him
   localparam logic [15:0] HOST_ADDR = 16'h8000;

   // scm registers
   localparam logic [15:0] REG_VENDOR   = 16'd0;
   localparam logic [15:0] REG_DEVICE   = 16'd1;
   localparam logic [15:0] REG_NUM_MOD  = 16'd2;
   localparam logic [15:0] REG_SYS_CTRL = 16'd3;
   // sys_ctrl bits
   localparam int SYS_CTRL_SYS_RST = 0;
   localparam int SYS_CTRL_CPU_RST = 1;

   // word positions inside a packet
   localparam logic [PTR_W-1:0] WORD_DEST  = 3'd0;
   localparam logic [PTR_W-1:0] WORD_SRC   = 3'd1;
   localparam logic [PTR_W-1:0] WORD_FLAGS = 3'd2;
   localparam logic [PTR_W-1:0] WORD_ADDR  = 3'd3;
   localparam logic [PTR_W-1:0] WORD_DATA  = 3'd4;

   typedef struct packed {
      logic        valid;
      logic        last;
      logic [15:0] data;
   } dii_flit;

   typedef enum logic [1:0] {
      reg_req   = 2'b00,
      reg_resp  = 2'b01,
      pkt_event = 2'b10
   } pkt_type_e;

   // request codes first, response codes after
   typedef enum logic [3:0] {
      read_16      = 4'b0000,
      write_16     = 4'b0100,
      resp_success = 4'b1110,
      resp_error   = 4'b1111
   } reg_sub_e;

   // flags word, type in 15:14, subtype in 13:10
   typedef struct packed {
      pkt_type_e  pkt_type;
      reg_sub_e   sub;
      logic [9:0] rsvd;
   } dii_flags;

   typedef enum logic {
      scm_rx,
      scm_tx
   } scm_state_e;

   typedef enum logic [2:0] {
      him_in_len,
      him_in_data,
      him_out_fill,
      him_out_len,
      him_out_data
   } him_state_e;
endpackage

`default_nettype wire

//--- host_if/osd_him.sv
// host interface; length-prefixed host words to ring flits and back, one packet buffered out
`timescale 1ns/1ps
`default_nettype none

module osd_him (
   input  wire logic             clk,
   input  wire logic             rst_n,
   input  wire logic             host_in_valid,
   input  wire logic [15:0]      host_in_data,
   output logic                  host_in_ready,
   output logic                  host_out_valid,
   output logic [15:0]           host_out_data,
   input  wire logic             host_out_ready,
   output dii_pkg::dii_flit      dii_out,
   input  wire logic             dii_out_ready,
   input  wire dii_pkg::dii_flit dii_in,
   output logic                  dii_in_ready
);
   import dii_pkg::*;

   him_state_e       in_state_q;
   him_state_e       out_state_q;
   logic             host_en_q;
   logic [15:0]      in_cnt_q;
   logic             in_fire;
   logic [15:0]      pkt_buf [MAX_PKT_LEN];
   logic [LEN_W-1:0] out_len_q;
   logic [PTR_W-1:0] rd_ptr_q;
   logic             dii_in_fire;
   logic             host_out_fire;

   // length words need no flit slot, data words wait for a free register
   assign host_in_ready = host_en_q &&
                          (in_state_q == him_in_len || !dii_out.valid || dii_out_ready);
   assign in_fire = host_in_valid && host_in_ready;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         host_en_q  <= 1'b0;
         in_state_q <= him_in_len;
         in_cnt_q   <= '0;
         dii_out    <= '0;
      end else begin
         // opens the host input one clock after reset
         host_en_q <= 1'b1;
         if (in_fire && in_state_q == him_in_data) begin
            dii_out.valid <= 1'b1;
            dii_out.last  <= (in_cnt_q == 16'd1);
            dii_out.data  <= host_in_data;
            in_cnt_q      <= in_cnt_q - 16'd1;
            if (in_cnt_q == 16'd1) begin
               in_state_q <= him_in_len;
            end
         end else begin
            if (dii_out_ready) begin
               dii_out.valid <= 1'b0;
            end
            // zero length packets are skipped
            if (in_fire && host_in_data != 16'd0) begin
               in_cnt_q   <= host_in_data;
               in_state_q <= him_in_data;
            end
         end
      end
   end

   // outbound, fill then replay count and words
   assign dii_in_ready   = (out_state_q == him_out_fill);
   assign dii_in_fire    = dii_in.valid && dii_in_ready;
   assign host_out_valid = (out_state_q != him_out_fill);
   assign host_out_data  = (out_state_q == him_out_len) ? 16'(out_len_q) : pkt_buf[rd_ptr_q];
   assign host_out_fire  = host_out_valid && host_out_ready;

   // words past MAX_PKT_LEN are dropped
   always_ff @(posedge clk) begin
      if (dii_in_fire && out_len_q < LEN_W'(MAX_PKT_LEN)) begin
         pkt_buf[out_len_q[PTR_W-1:0]] <= dii_in.data;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         out_state_q <= him_out_fill;
         out_len_q   <= '0;
         rd_ptr_q    <= '0;
      end else begin
         case (out_state_q)
            him_out_fill: begin
               if (dii_in_fire) begin
                  if (out_len_q < LEN_W'(MAX_PKT_LEN)) begin
                     out_len_q <= out_len_q + LEN_W'(1);
                  end
                  if (dii_in.last) begin
                     out_state_q <= him_out_len;
                  end
               end
            end
            him_out_len: begin
               if (host_out_fire) begin
                  rd_ptr_q    <= '0;
                  out_state_q <= him_out_data;
               end
            end
            him_out_data: begin
               if (host_out_fire) begin
                  rd_ptr_q <= rd_ptr_q + PTR_W'(1);
                  // final stored word sent
                  if (LEN_W'(rd_ptr_q) + LEN_W'(1) == out_len_q) begin
                     out_len_q   <= '0;
                     out_state_q <= him_out_fill;
                  end
               end
            end
            default: out_state_q <= him_out_fill;
         endcase
      end
   end
endmodule

`default_nettype wire

//--- list.f
common/dii_pkg.sv
ring/ring_router.sv
host_if/osd_him.sv
scm/osd_scm.sv
rtl/debug_interface.sv
verif/tb_debug_interface.sv

//--- ring/ring_router.sv
// one debug ring stop; delivers packets for its id, forwards the rest, merges local traffic
`timescale 1ns/1ps
`default_nettype none

module ring_router #(
   parameter logic [15:0] id = 16'd0
) (
   input  wire logic             clk,
   input  wire logic             rst_n,
   input  wire dii_pkg::dii_flit ring_in,
   output logic                  ring_in_ready,
   output dii_pkg::dii_flit      ring_out,
   input  wire logic             ring_out_ready,
   input  wire dii_pkg::dii_flit local_in,
   output logic                  local_in_ready,
   output dii_pkg::dii_flit      local_out,
   input  wire logic             local_out_ready
);
   import dii_pkg::*;

   logic first_q;       // next ring flit opens a packet
   logic route_local_q; // route of the packet in flight
   logic lock_q;        // ring_out held until last flit
   logic owner_local_q; // lock owner, local_in when set
   logic to_local;
   logic ring_out_free;
   logic local_out_free;
   logic ring_fire;
   logic local_fire;

   // destination word decides, later flits follow it
   assign to_local = first_q ? (ring_in.data == id) : route_local_q;

   assign ring_out_free  = !ring_out.valid || ring_out_ready;
   assign local_out_free = !local_out.valid || local_out_ready;

   // ring traffic wins ring_out unless local_in holds the lock
   assign ring_in_ready  = to_local ? local_out_free :
                           (ring_out_free && !(lock_q && owner_local_q));
   assign local_in_ready = ring_out_free &&
                           (lock_q ? owner_local_q : !(ring_in.valid && !to_local));

   assign ring_fire  = ring_in.valid && ring_in_ready;
   assign local_fire = local_in.valid && local_in_ready;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         first_q       <= 1'b1;
         route_local_q <= 1'b0;
         lock_q        <= 1'b0;
         owner_local_q <= 1'b0;
         ring_out      <= '0;
         local_out     <= '0;
      end else begin
         if (ring_fire) begin
            first_q       <= ring_in.last;
            route_local_q <= to_local;
         end

         // ring_out register, one source per cycle
         if (ring_fire && !to_local) begin
            ring_out      <= ring_in;
            lock_q        <= !ring_in.last;
            owner_local_q <= 1'b0;
         end else if (local_fire) begin
            ring_out      <= local_in;
            lock_q        <= !local_in.last;
            owner_local_q <= 1'b1;
         end else if (ring_out_ready) begin
            ring_out.valid <= 1'b0;
         end

         // delivery to the attached module
         if (ring_fire && to_local) begin
            local_out <= ring_in;
         end else if (local_out_ready) begin
            local_out.valid <= 1'b0;
         end
      end
   end
endmodule

`default_nettype wire

//--- rtl/debug_interface.sv
// debug link top level; host interface, ring of routers and scm on stop 0
`timescale 1ns/1ps
`default_nettype none

module debug_interface (
   input  wire logic                                        clk,
   input  wire logic                                        rst_n,
   // host word stream in
   input  wire logic                                        host_in_valid,
   input  wire logic [15:0]                                 host_in_data,
   output logic                                             host_in_ready,
   // host word stream out
   output logic                                             host_out_valid,
   output logic [15:0]                                      host_out_data,
   input  wire logic                                        host_out_ready,
   // local ports of stops 1 and up
   output dii_pkg::dii_flit [dii_pkg::NUM_MODULES-1:1]      local_out,
   input  wire logic [dii_pkg::NUM_MODULES-1:1]             local_out_ready,
   input  wire dii_pkg::dii_flit [dii_pkg::NUM_MODULES-1:1] local_in,
   output logic [dii_pkg::NUM_MODULES-1:1]                  local_in_ready,
   // reset requests
   output logic                                             sys_rst,
   output logic                                             cpu_rst
);
   import dii_pkg::*;

   // link i enters router i, the top link returns to the him
   dii_flit [NUM_MODULES:0] link;
   logic [NUM_MODULES:0]    link_ready;

   // local ports per stop
   dii_flit [NUM_MODULES-1:0] stop_out;
   logic [NUM_MODULES-1:0]    stop_out_ready;
   dii_flit [NUM_MODULES-1:0] stop_in;
   logic [NUM_MODULES-1:0]    stop_in_ready;

   // stops 1 and up face the top level, stop 0 stays with the scm
   assign local_out = stop_out[NUM_MODULES-1:1];
   assign stop_out_ready[NUM_MODULES-1:1] = local_out_ready;
   assign stop_in[NUM_MODULES-1:1] = local_in;
   assign local_in_ready = stop_in_ready[NUM_MODULES-1:1];

   osd_him u_him (
      .clk            (clk),
      .rst_n          (rst_n),
      .host_in_valid  (host_in_valid),
      .host_in_data   (host_in_data),
      .host_in_ready  (host_in_ready),
      .host_out_valid (host_out_valid),
      .host_out_data  (host_out_data),
      .host_out_ready (host_out_ready),
      .dii_out        (link[0]),
      .dii_out_ready  (link_ready[0]),
      .dii_in         (link[NUM_MODULES]),
      .dii_in_ready   (link_ready[NUM_MODULES])
   );

   for (genvar i = 0; i < NUM_MODULES; i++) begin : g_stop
      ring_router #(.id(16'(i))) u_router (
         .clk             (clk),
         .rst_n           (rst_n),
         .ring_in         (link[i]),
         .ring_in_ready   (link_ready[i]),
         .ring_out        (link[i+1]),
         .ring_out_ready  (link_ready[i+1]),
         .local_in        (stop_in[i]),
         .local_in_ready  (stop_in_ready[i]),
         .local_out       (stop_out[i]),
         .local_out_ready (stop_out_ready[i])
      );
   end

   // scm answers at address 0
   osd_scm u_scm (
      .clk             (clk),
      .rst_n           (rst_n),
      .debug_in        (stop_out[0]),
      .debug_in_ready  (stop_out_ready[0]),
      .debug_out       (stop_in[0]),
      .debug_out_ready (stop_in_ready[0]),
      .sys_rst         (sys_rst),
      .cpu_rst         (cpu_rst)
   );
endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# build with verilator, run, and decide on the log contents
verilator --binary --timing --assert --top-module tb_debug_interface -f list.f -o sim_tb \
   && ./obj_dir/sim_tb > sim.log \
   && cat sim.log \
   && grep -q 'All tests passed!' sim.log \
   && echo 'PASS' \
   || { echo 'FAIL'; exit 1; }

//--- scm/osd_scm.sv
// subnet control module on stop 0; answers register requests and holds the reset requests
`timescale 1ns/1ps
`default_nettype none

module osd_scm (
   input  wire logic             clk,
   input  wire logic             rst_n,
   input  wire dii_pkg::dii_flit debug_in,
   output logic                  debug_in_ready,
   output dii_pkg::dii_flit      debug_out,
   input  wire logic             debug_out_ready,
   output logic                  sys_rst,
   output logic                  cpu_rst
);
   import dii_pkg::*;

   scm_state_e       state_q;
   logic [PTR_W-1:0] rx_cnt_q;
   logic [PTR_W-1:0] tx_cnt_q;
   logic [15:0]      src_q;
   logic [15:0]      addr_q;
   logic [15:0]      rdata_q;
   dii_flags         flags_q;
   logic             ok_q;
   logic             has_data_q;
   logic [15:0]      src_n;
   logic [15:0]      addr_n;
   logic [15:0]      rdata;
   dii_flags         flags_n;
   dii_flags         resp_flags;
   logic             rx_fire;
   logic             rx_done;
   logic             is_read;
   logic             is_write;
   logic             rd_ok;
   logic             ctrl_wr;

   assign debug_in_ready = (state_q == scm_rx);
   assign rx_fire = debug_in.valid && debug_in_ready;
   assign rx_done = rx_fire && debug_in.last;

   // request fields including this cycle's flit
   always_comb begin
      src_n   = src_q;
      flags_n = flags_q;
      addr_n  = addr_q;
      if (rx_fire) begin
         case (rx_cnt_q)
            WORD_SRC:   src_n = debug_in.data;
            WORD_FLAGS: flags_n = dii_flags'(debug_in.data);
            WORD_ADDR:  addr_n = debug_in.data;
            default:    ;
         endcase
      end
   end

   // a read ends on the address word, a write on the data word
   assign is_read  = flags_n.pkt_type == reg_req && flags_n.sub == read_16 &&
                     rx_cnt_q == WORD_ADDR;
   assign is_write = flags_n.pkt_type == reg_req && flags_n.sub == write_16 &&
                     rx_cnt_q == WORD_DATA;
   assign ctrl_wr  = is_write && addr_n == REG_SYS_CTRL;

   // register map
   always_comb begin
      rdata = '0;
      rd_ok = 1'b1;
      case (addr_n)
         REG_VENDOR:  rdata = SYSTEM_VENDOR_ID;
         REG_DEVICE:  rdata = SYSTEM_DEVICE_ID;
         REG_NUM_MOD: rdata = 16'(NUM_MODULES);
         REG_SYS_CTRL: begin
            rdata[SYS_CTRL_SYS_RST] = sys_rst;
            rdata[SYS_CTRL_CPU_RST] = cpu_rst;
         end
         default: rd_ok = 1'b0;
      endcase
   end

   // response words carry source 0
   assign resp_flags = '{pkt_type: reg_resp, sub: ok_q ? resp_success : resp_error, rsvd: '0};

   always_comb begin
      debug_out.valid = (state_q == scm_tx);
      debug_out.last  = (tx_cnt_q == (has_data_q ? WORD_DATA : WORD_ADDR));
      case (tx_cnt_q)
         WORD_DEST:  debug_out.data = src_q;
         WORD_SRC:   debug_out.data = 16'd0;
         WORD_FLAGS: debug_out.data = resp_flags;
         WORD_ADDR:  debug_out.data = addr_q;
         default:    debug_out.data = rdata_q;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state_q    <= scm_rx;
         rx_cnt_q   <= '0;
         tx_cnt_q   <= '0;
         ok_q       <= 1'b0;
         has_data_q <= 1'b0;
         sys_rst    <= 1'b0;
         cpu_rst    <= 1'b0;
      end else begin
         if (rx_done) begin
            state_q    <= scm_tx;
            rx_cnt_q   <= '0;
            tx_cnt_q   <= '0;
            ok_q       <= is_read ? rd_ok : ctrl_wr;
            has_data_q <= is_read && rd_ok;
            // write data is the last request flit
            if (ctrl_wr) begin
               sys_rst <= debug_in.data[SYS_CTRL_SYS_RST];
               cpu_rst <= debug_in.data[SYS_CTRL_CPU_RST];
            end
         end else if (rx_fire && rx_cnt_q != '1) begin
            // long requests saturate and end up as errors
            rx_cnt_q <= rx_cnt_q + PTR_W'(1);
         end
         if (debug_out.valid && debug_out_ready) begin
            tx_cnt_q <= tx_cnt_q + PTR_W'(1);
            if (debug_out.last) begin
               state_q <= scm_rx;
            end
         end
      end
   end

   // request payload
   always_ff @(posedge clk) begin
      src_q   <= src_n;
      flags_q <= flags_n;
      addr_q  <= addr_n;
      if (rx_done) begin
         rdata_q <= rdata;
      end
   end
endmodule

`default_nettype wire

//--- verif/tb_debug_interface.sv
// testbench for the debug link; seeded random host and local traffic checked against a model
`timescale 1ns/1ps
`default_nettype none

module tb_debug_interface;
   import dii_pkg::*;

   // cycles any single wait may take
   localparam int TIMEOUT = 200;

   logic                      clk = 1'b0;
   logic                      rst_n;
   logic                      host_in_valid;
   logic [15:0]               host_in_data;
   logic                      host_in_ready;
   logic                      host_out_valid;
   logic [15:0]               host_out_data;
   logic                      host_out_ready;
   dii_flit [NUM_MODULES-1:1] local_out;
   logic [NUM_MODULES-1:1]    local_out_ready;
   dii_flit [NUM_MODULES-1:1] local_in;
   logic [NUM_MODULES-1:1]    local_in_ready;
   logic                      sys_rst;
   logic                      cpu_rst;

   int          seed = 32'h52fd;
   int          checks;
   int          errors;
   int          test_checks;
   int          test_errors;
   // packet going into the DUT
   logic [15:0] pkt_q[$];
   // words expected on host_out after the length
   logic [15:0] exp_q[$];
   // model copy of the sys_ctrl bits
   logic [1:0]  ctrl_model;

   debug_interface dut_i (
      .clk             (clk),
      .rst_n           (rst_n),
      .host_in_valid   (host_in_valid),
      .host_in_data    (host_in_data),
      .host_in_ready   (host_in_ready),
      .host_out_valid  (host_out_valid),
      .host_out_data   (host_out_data),
      .host_out_ready  (host_out_ready),
      .local_out       (local_out),
      .local_out_ready (local_out_ready),
      .local_in        (local_in),
      .local_in_ready  (local_in_ready),
      .sys_rst         (sys_rst),
      .cpu_rst         (cpu_rst)
   );

   // 100 ns period
   always #50 clk = ~clk;

   // flags word with type on top, subtype below and the rest zero
   function automatic logic [15:0] flags_word(input pkt_type_e t, input reg_sub_e s);
      return {t, s, 10'd0};
   endfunction

   task automatic check_word(input string name, input logic [15:0] exp, input logic [15:0] act);
      checks++;
      assert (act === exp) else begin
         $display("Error at %0d ns: %s expected %h, actual %h", $time, name, exp, act);
         errors++;
      end
   endtask

   task automatic report_test(input string name);
      $display("%s: %0d checks, %0d errors", name, checks - test_checks, errors - test_errors);
      test_checks = checks;
      test_errors = errors;
   endtask

   // one word on host_in held until accepted
   task automatic host_word(input logic [15:0] w);
      logic done;
      int   n;
      done = 1'b0;
      n = 0;
      host_in_valid = 1'b1;
      host_in_data  = w;
      while (!done && n < TIMEOUT) begin
         @(negedge clk);
         done = host_in_ready;
         @(posedge clk);
         #1;
         n++;
      end
      host_in_valid = 1'b0;
      if (!done) begin
         $display("timeout at %0d ns: host_in never accepted word %h", $time, w);
         errors++;
      end
   endtask

   // length word first, then the packet
   task automatic send_host_packet();
      host_word(16'(pkt_q.size()));
      foreach (pkt_q[i]) begin
         host_word(pkt_q[i]);
      end
   endtask

   // one word from host_out while ready toggles at random
   task automatic host_take(output logic [15:0] w);
      logic [31:0] r;
      logic        done;
      int          n;
      done = 1'b0;
      n = 0;
      w = '0;
      while (!done && n < TIMEOUT) begin
         r = $random(seed);
         host_out_ready = r[0];
         @(negedge clk);
         if (host_out_valid && host_out_ready) begin
            w = host_out_data;
            done = 1'b1;
         end
         @(posedge clk);
         #1;
         n++;
      end
      host_out_ready = 1'b0;
      if (!done) begin
         $display("timeout at %0d ns: no word came out of host_out", $time);
         errors++;
      end
   endtask

   task automatic receive_host_packet();
      logic [15:0] len;
      logic [15:0] w;
      host_take(len);
      check_word("host_out_data (length)", 16'(exp_q.size()), len);
      // never read more than one buffer
      for (int i = 0; i < int'(len) && i < MAX_PKT_LEN; i++) begin
         host_take(w);
         if (i < exp_q.size()) begin
            check_word($sformatf("host_out_data[%0d]", i), exp_q[i], w);
         end
      end
   endtask

   // request sent whole, then the response collected
   task automatic host_exchange();
      send_host_packet();
      receive_host_packet();
   endtask

   // one flit into local_in[k] while local_out_ready toggles
   task automatic local_word(input int k, input logic [15:0] w, input logic l);
      logic [31:0] r;
      logic        done;
      int          n;
      done = 1'b0;
      n = 0;
      local_in[k] = '{valid: 1'b1, last: l, data: w};
      while (!done && n < TIMEOUT) begin
         r = $random(seed);
         local_out_ready = r[3:1];
         @(negedge clk);
         done = local_in_ready[k];
         @(posedge clk);
         #1;
         n++;
      end
      local_in[k] = '0;
      local_out_ready = '0;
      if (!done) begin
         $display("timeout at %0d ns: local_in[%0d] never accepted word %h", $time, k, w);
         errors++;
      end
   endtask

   task automatic send_local_packet(input int k);
      foreach (pkt_q[i]) begin
         local_word(k, pkt_q[i], i == pkt_q.size() - 1);
      end
   endtask

   // one flit from local_out[k] with random ready
   task automatic local_take(input int k, output logic [15:0] w, output logic l);
      logic [31:0] r;
      logic        done;
      int          n;
      done = 1'b0;
      n = 0;
      w = '0;
      l = 1'b0;
      while (!done && n < TIMEOUT) begin
         r = $random(seed);
         local_out_ready[k] = r[0];
         @(negedge clk);
         if (local_out[k].valid && local_out_ready[k]) begin
            w = local_out[k].data;
            l = local_out[k].last;
            done = 1'b1;
         end
         @(posedge clk);
         #1;
         n++;
      end
      local_out_ready[k] = 1'b0;
      if (!done) begin
         $display("timeout at %0d ns: no flit came out of local_out[%0d]", $time, k);
         errors++;
      end
   endtask

   // delivered packet must match what was sent, last only on the final word
   task automatic receive_local_packet(input int k);
      logic [15:0] w;
      logic        l;
      for (int i = 0; i < pkt_q.size(); i++) begin
         local_take(k, w, l);
         check_word($sformatf("local_out[%0d].data[%0d]", k, i), pkt_q[i], w);
         check_word($sformatf("local_out[%0d].last[%0d]", k, i),
                    {15'd0, i == pkt_q.size() - 1}, {15'd0, l});
      end
   endtask

   // register request from the host to the scm at address 0
   task automatic make_request(input reg_sub_e s, input logic [15:0] addr,
                               input logic [15:0] data);
      pkt_q = {16'd0, HOST_ADDR, flags_word(reg_req, s), addr};
      if (s == write_16) begin
         pkt_q.push_back(data);
      end
   endtask

   // response as the register map predicts it
   task automatic expect_response(input reg_sub_e s, input logic [15:0] addr,
                                  input logic has_data, input logic [15:0] data);
      exp_q = {HOST_ADDR, 16'd0, flags_word(reg_resp, s), addr};
      if (has_data) begin
         exp_q.push_back(data);
      end
   endtask

   task automatic random_packet(input logic [15:0] dest, input int len);
      logic [31:0] r;
      pkt_q = {dest};
      for (int i = 1; i < len; i++) begin
         r = $random(seed);
         pkt_q.push_back(r[15:0]);
      end
   endtask

   initial begin
      logic [31:0] r;
      logic [15:0] wdata;
      logic [15:0] addr;
      int          k;
      int          len;
      rst_n = 1'b0;
      host_in_valid = 1'b0;
      host_in_data = '0;
      host_out_ready = 1'b0;
      local_out_ready = '0;
      local_in = '0;
      checks = 0;
      errors = 0;
      test_checks = 0;
      test_errors = 0;
      ctrl_model = 2'b00;
      repeat (5) @(posedge clk);
      #1;
      rst_n = 1'b1;

      // constant registers
      make_request(read_16, REG_VENDOR, 16'd0);
      expect_response(resp_success, REG_VENDOR, 1'b1, SYSTEM_VENDOR_ID);
      host_exchange();
      make_request(read_16, REG_DEVICE, 16'd0);
      expect_response(resp_success, REG_DEVICE, 1'b1, SYSTEM_DEVICE_ID);
      host_exchange();
      make_request(read_16, REG_NUM_MOD, 16'd0);
      expect_response(resp_success, REG_NUM_MOD, 1'b1, 16'(NUM_MODULES));
      host_exchange();
      report_test("constant register reads");

      // sys_ctrl write then reset pins and read back
      for (int i = 0; i < 6; i++) begin
         r = $random(seed);
         wdata = r[15:0];
         make_request(write_16, REG_SYS_CTRL, wdata);
         expect_response(resp_success, REG_SYS_CTRL, 1'b0, 16'd0);
         host_exchange();
         ctrl_model = wdata[1:0];
         check_word("sys_rst", {15'd0, ctrl_model[0]}, {15'd0, sys_rst});
         check_word("cpu_rst", {15'd0, ctrl_model[1]}, {15'd0, cpu_rst});
         make_request(read_16, REG_SYS_CTRL, 16'd0);
         expect_response(resp_success, REG_SYS_CTRL, 1'b1, {14'd0, ctrl_model});
         host_exchange();
      end
      report_test("control register writes");

      // unmapped reads and a write to a read-only register
      for (int i = 0; i < 4; i++) begin
         r = $random(seed);
         addr = 16'd4 + 16'(r[5:0]);
         make_request(read_16, addr, 16'd0);
         expect_response(resp_error, addr, 1'b0, 16'd0);
         host_exchange();
      end
      r = $random(seed);
      make_request(write_16, REG_VENDOR, r[15:0]);
      expect_response(resp_error, REG_VENDOR, 1'b0, 16'd0);
      host_exchange();
      // rejected write leaves the reset bits alone
      check_word("sys_rst", {15'd0, ctrl_model[0]}, {15'd0, sys_rst});
      check_word("cpu_rst", {15'd0, ctrl_model[1]}, {15'd0, cpu_rst});
      report_test("error responses");

      // host to attached module with send and drain in parallel
      for (int i = 0; i < 8; i++) begin
         r = $random(seed);
         k = 1 + int'(r[7:0]) % (NUM_MODULES - 1);
         len = 4 + int'(r[15:8]) % 5;
         random_packet(16'(k), len);
         fork
            send_host_packet();
            receive_local_packet(k);
         join
      end
      report_test("delivery to attached modules");

      // attached module to host
      for (int i = 0; i < 8; i++) begin
         r = $random(seed);
         k = 1 + int'(r[7:0]) % (NUM_MODULES - 1);
         len = 4 + int'(r[15:8]) % 5;
         random_packet(HOST_ADDR, len);
         exp_q = pkt_q;
         fork
            send_local_packet(k);
            receive_host_packet();
         join
      end
      report_test("return to the host");

      $display("total: %0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end
endmodule

`default_nettype wire
